//--- Bender.yml
package:
  name: store_queue

sources:
  - source/stq_pkg.sv
  - source/stq_entry.sv
  - source/stq_ptr_ctrl.sv
  - source/stq_snoop_merge.sv
  - source/stq_top.sv
  - target: test
    files:
      - testbench/tb_stq.sv

//--- source/stq_entry.sv
`timescale 1ns/1ps

module stq_entry
  import stq_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  idx_t       i_idx,
  input  logic       i_load,
  input  disp_req_t  i_disp,
  input  addr_upd_t  i_addr_upd,
  input  data_upd_t  i_data_upd,
  input  commit_t    i_commit,
  input  logic       i_head,
  input  logic       i_drain_go,
  input  logic       i_snp_valid,
  input  paddr_t     i_snp_paddr,
  output stq_state_t o_state,
  output st_wr_t     o_wr,
  output be_t        o_snp_be,
  output dword_t     o_snp_data
);

  stq_state_t r_state;
  stq_state_t w_state_next;

  cmt_id_t  r_cmt_id;
  paddr_t   r_paddr;
  st_size_t r_size;
  dword_t   r_data;
  logic     r_addr_v;
  logic     r_data_v;
  logic     r_cmted;

  logic w_load;
  logic w_waiting;
  logic w_addr_hit;
  logic w_data_hit;
  logic w_cmt_hit;
  logic w_kill;
  logic w_snp_hit;

  assign w_load    = i_load && i_disp.valid && (r_state == STQ_FREE);
  assign w_waiting = (r_state == STQ_WAIT_OPS) || (r_state == STQ_WAIT_COMMIT);

  // operand updates only land while the slot is still collecting them
  assign w_addr_hit = i_addr_upd.valid && (i_addr_upd.idx == i_idx) &&
                      (r_state == STQ_WAIT_OPS);
  assign w_data_hit = i_data_upd.valid && (i_data_upd.idx == i_idx) &&
                      (r_state == STQ_WAIT_OPS);

  assign w_cmt_hit = i_commit.valid && (i_commit.cmt_id == r_cmt_id) && w_waiting;

  // a commit arriving with the flush still protects this slot
  assign w_kill = i_commit.flush && w_waiting && !r_cmted && !w_cmt_hit;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      STQ_FREE: begin
        if (w_load) begin
          w_state_next = STQ_WAIT_OPS;
        end
      end
      STQ_WAIT_OPS: begin
        if (w_kill) begin
          w_state_next = STQ_DEAD;
        end else if (r_addr_v && r_data_v) begin
          w_state_next = STQ_WAIT_COMMIT;
        end
      end
      STQ_WAIT_COMMIT: begin
        if (w_kill) begin
          w_state_next = STQ_DEAD;
        end else if (r_cmted) begin
          w_state_next = STQ_COMMITTED;
        end
      end
      STQ_COMMITTED: begin
        if (i_head && i_drain_go) begin
          w_state_next = STQ_DRAINING;
        end
      end
      STQ_DRAINING: begin
        w_state_next = STQ_FREE;  // write goes out on this edge
      end
      STQ_DEAD: begin
        if (i_head) begin
          w_state_next = STQ_FREE;  // retired without a write
        end
      end
      default: begin
        w_state_next = STQ_FREE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state  <= STQ_FREE;
      r_addr_v <= 1'b0;
      r_data_v <= 1'b0;
      r_cmted  <= 1'b0;
    end else begin
      r_state <= w_state_next;
      if (r_state == STQ_FREE) begin  // clean flags for the next store
        r_addr_v <= 1'b0;
        r_data_v <= 1'b0;
        r_cmted  <= 1'b0;
      end else begin
        if (w_addr_hit) begin
          r_addr_v <= 1'b1;
        end
        if (w_data_hit) begin
          r_data_v <= 1'b1;
        end
        if (w_cmt_hit) begin
          r_cmted <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_cmt_id <= i_disp.cmt_id;
    end
    if (w_addr_hit) begin
      r_paddr <= i_addr_upd.paddr;
      r_size  <= i_addr_upd.size;
    end
    if (w_data_hit) begin
      r_data <= i_data_upd.data;
    end
  end

  assign o_state = r_state;

  assign o_wr = '{paddr: {r_paddr[$bits(paddr_t)-1:3], 3'b000},
                  be:    gen_be(r_size, r_paddr[2:0]),
                  data:  align_data(r_data, r_paddr[2:0])};

  // only stores past commit are visible to loads
  assign w_snp_hit = i_snp_valid &&
                     ((r_state == STQ_COMMITTED) || (r_state == STQ_DRAINING)) &&
                     (r_paddr[$bits(paddr_t)-1:3] == i_snp_paddr[$bits(paddr_t)-1:3]);

  assign o_snp_be   = w_snp_hit ? o_wr.be : '0;
  assign o_snp_data = w_snp_hit ? o_wr.data : '0;

endmodule

//--- source/stq_pkg.sv
package stq_pkg;

  localparam int STQ_ENTRIES    = 8;
  localparam int STQ_IDX_W      = 3;
  localparam int STQ_WR_CREDITS = 2;
  localparam int STQ_CNT_W      = STQ_IDX_W + 1;  // occupancy 0..STQ_ENTRIES
  localparam int STQ_CRD_W      = $clog2(STQ_WR_CREDITS + 1);

  typedef logic [STQ_IDX_W-1:0] idx_t;
  typedef logic [5:0]           cmt_id_t;
  typedef logic [31:0]          paddr_t;
  typedef logic [63:0]          dword_t;
  typedef logic [7:0]           be_t;

  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W,
    SZ_D
  } st_size_t;

  typedef enum logic [2:0] {
    STQ_FREE,
    STQ_WAIT_OPS,     // address and/or data still missing
    STQ_WAIT_COMMIT,
    STQ_COMMITTED,
    STQ_DRAINING,
    STQ_DEAD
  } stq_state_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
  } disp_req_t;

  typedef struct packed {
    logic     valid;
    idx_t     idx;
    paddr_t   paddr;
    st_size_t size;
  } addr_upd_t;

  typedef struct packed {
    logic   valid;
    idx_t   idx;
    dword_t data;  // raw, right aligned
  } data_upd_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    logic    flush;
  } commit_t;

  typedef struct packed {
    paddr_t paddr;  // dword aligned
    be_t    be;
    dword_t data;   // already in its byte lanes
  } st_wr_t;

  typedef struct packed {
    logic   valid;
    be_t    be;
    dword_t data;
  } snp_resp_t;

  function automatic be_t gen_be(st_size_t size, logic [2:0] off);
    be_t mask;
    case (size)
      SZ_B:    mask = 8'h01;
      SZ_H:    mask = 8'h03;
      SZ_W:    mask = 8'h0f;
      default: mask = 8'hff;
    endcase
    return be_t'(mask << off);
  endfunction

  function automatic dword_t align_data(dword_t data, logic [2:0] off);
    return data << {off, 3'b000};  // byte offset to bit shift
  endfunction

endpackage

//--- source/stq_ptr_ctrl.sv
`timescale 1ns/1ps

module stq_ptr_ctrl
  import stq_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  disp_req_t              i_disp,
  input  stq_state_t             i_states [STQ_ENTRIES],
  input  st_wr_t                 i_wrs [STQ_ENTRIES],
  input  logic                   i_wr_credit,
  output logic                   o_disp_ready,
  output idx_t                   o_disp_idx,
  output logic [STQ_ENTRIES-1:0] o_load_oh,
  output logic [STQ_ENTRIES-1:0] o_head_oh,
  output logic                   o_drain_go,
  output idx_t                   o_head_idx,
  output logic                   o_wr_valid,
  output st_wr_t                 o_wr
);

  idx_t                 r_alloc_ptr;
  idx_t                 r_out_ptr;
  logic [STQ_CNT_W-1:0] r_count;
  logic [STQ_CRD_W-1:0] r_credits;

  stq_state_t w_head_state;
  logic       w_accept;
  logic       w_send;
  logic       w_release;

  assign o_disp_ready = (r_count != STQ_CNT_W'(STQ_ENTRIES));
  assign o_disp_idx   = r_alloc_ptr;
  assign o_head_idx   = r_out_ptr;
  assign w_accept     = i_disp.valid && o_disp_ready;

  assign w_head_state = i_states[r_out_ptr];

  // credit is taken when the head is picked, one slot in flight at most
  assign o_drain_go = (w_head_state == STQ_COMMITTED) && (r_credits != '0);
  assign w_send     = (w_head_state == STQ_DRAINING);
  assign w_release  = w_send || (w_head_state == STQ_DEAD);

  always_comb begin
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      o_load_oh[i] = w_accept && (r_alloc_ptr == idx_t'(i));
      o_head_oh[i] = (r_out_ptr == idx_t'(i));
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alloc_ptr <= '0;
      r_out_ptr   <= '0;
      r_count     <= '0;
      r_credits   <= STQ_CRD_W'(STQ_WR_CREDITS);
      o_wr_valid  <= 1'b0;
    end else begin
      o_wr_valid <= w_send;
      if (w_accept) begin
        r_alloc_ptr <= r_alloc_ptr + 1'b1;  // wraps at STQ_ENTRIES
      end
      if (w_release) begin
        r_out_ptr <= r_out_ptr + 1'b1;
      end

      case ({w_accept, w_release})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase

      // send and returned credit together cancel out
      case ({o_drain_go, i_wr_credit})
        2'b10:   r_credits <= r_credits - 1'b1;
        2'b01:   r_credits <= r_credits + 1'b1;
        default: r_credits <= r_credits;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_send) begin
      o_wr <= i_wrs[r_out_ptr];
    end
  end

endmodule

//--- source/stq_snoop_merge.sv
`timescale 1ns/1ps

module stq_snoop_merge
  import stq_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_snp_valid,
  input  idx_t      i_head_idx,
  input  be_t       i_be [STQ_ENTRIES],
  input  dword_t    i_data [STQ_ENTRIES],
  output snp_resp_t o_snp
);

  idx_t   w_slot;
  be_t    w_be;
  dword_t w_data;

  logic   r_valid;
  be_t    r_be;
  dword_t r_data;

  // oldest first so a younger store overwrites the bytes before it
  always_comb begin
    w_be   = '0;
    w_data = '0;
    w_slot = i_head_idx;
    for (int k = 0; k < STQ_ENTRIES; k++) begin
      w_slot = idx_t'(i_head_idx + k);  // wraps around the ring
      for (int b = 0; b < $bits(be_t); b++) begin
        if (i_be[w_slot][b]) begin
          w_be[b]          = 1'b1;
          w_data[b*8 +: 8] = i_data[w_slot][b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_snp_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_be   <= w_be;  // zero when nothing matched
    r_data <= w_data;
  end

  assign o_snp = '{valid: r_valid, be: r_be, data: r_data};

endmodule

//--- source/stq_top.sv
`timescale 1ns/1ps

module stq_top
  import stq_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  disp_req_t i_disp,
  input  addr_upd_t i_addr_upd,
  input  data_upd_t i_data_upd,
  input  commit_t   i_commit,
  input  logic      i_wr_credit,
  input  logic      i_snp_valid,
  input  paddr_t    i_snp_paddr,
  output logic      o_disp_ready,
  output idx_t      o_disp_idx,
  output logic      o_wr_valid,
  output st_wr_t    o_wr,
  output snp_resp_t o_snp
);

  stq_state_t             w_states [STQ_ENTRIES];
  st_wr_t                 w_wrs [STQ_ENTRIES];
  be_t                    w_snp_be [STQ_ENTRIES];
  dword_t                 w_snp_data [STQ_ENTRIES];
  logic [STQ_ENTRIES-1:0] w_load_oh;
  logic [STQ_ENTRIES-1:0] w_head_oh;
  logic                   w_drain_go;
  idx_t                   w_head_idx;

  for (genvar g = 0; g < STQ_ENTRIES; g++) begin : g_entry
    stq_entry entry_i (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_idx       (idx_t'(g)),
      .i_load      (w_load_oh[g]),
      .i_disp      (i_disp),
      .i_addr_upd  (i_addr_upd),
      .i_data_upd  (i_data_upd),
      .i_commit    (i_commit),
      .i_head      (w_head_oh[g]),
      .i_drain_go  (w_drain_go),
      .i_snp_valid (i_snp_valid),
      .i_snp_paddr (i_snp_paddr),
      .o_state     (w_states[g]),
      .o_wr        (w_wrs[g]),
      .o_snp_be    (w_snp_be[g]),
      .o_snp_data  (w_snp_data[g])
    );
  end

  stq_ptr_ctrl ptr_ctrl_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_states     (w_states),
    .i_wrs        (w_wrs),
    .i_wr_credit  (i_wr_credit),
    .o_disp_ready (o_disp_ready),
    .o_disp_idx   (o_disp_idx),
    .o_load_oh    (w_load_oh),
    .o_head_oh    (w_head_oh),
    .o_drain_go   (w_drain_go),
    .o_head_idx   (w_head_idx),
    .o_wr_valid   (o_wr_valid),
    .o_wr         (o_wr)
  );

  stq_snoop_merge snoop_merge_i (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_snp_valid (i_snp_valid),
    .i_head_idx  (w_head_idx),
    .i_be        (w_snp_be),
    .i_data      (w_snp_data),
    .o_snp       (o_snp)
  );

endmodule

//--- store_queue.f
source/stq_pkg.sv
source/stq_entry.sv
source/stq_ptr_ctrl.sv
source/stq_snoop_merge.sv
source/stq_top.sv
testbench/tb_stq.sv

//--- testbench/tb_stq.sv
`timescale 1ns/1ps

module tb_stq
  import stq_pkg::*;
();

  logic      i_clk;
  logic      i_reset_n;
  disp_req_t i_disp;
  addr_upd_t i_addr_upd;
  data_upd_t i_data_upd;
  commit_t   i_commit;
  logic      i_wr_credit;
  logic      i_snp_valid;
  paddr_t    i_snp_paddr;
  logic      o_disp_ready;
  idx_t      o_disp_idx;
  logic      o_wr_valid;
  st_wr_t    o_wr;
  snp_resp_t o_snp;

  integer    seed;
  cmt_id_t   next_cmt;
  idx_t      exp_idx;                // model allocation pointer
  cmt_id_t   st_cmt [STQ_ENTRIES];   // model copy of each slot's store
  paddr_t    st_paddr [STQ_ENTRIES];
  st_size_t  st_size [STQ_ENTRIES];
  dword_t    st_data [STQ_ENTRIES];
  st_wr_t    exp_q [$];              // expected cache writes in age order
  int        wr_count;
  logic      auto_credit;            // cache returns a credit per write
  int        credit_pend;
  paddr_t    snp_addr;
  snp_resp_t snp_exp;

  stq_top dut_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_addr_upd   (i_addr_upd),
    .i_data_upd   (i_data_upd),
    .i_commit     (i_commit),
    .i_wr_credit  (i_wr_credit),
    .i_snp_valid  (i_snp_valid),
    .i_snp_paddr  (i_snp_paddr),
    .o_disp_ready (o_disp_ready),
    .o_disp_idx   (o_disp_idx),
    .o_wr_valid   (o_wr_valid),
    .o_wr         (o_wr),
    .o_snp        (o_snp)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want));
    end
  endtask

  function automatic dword_t keep_low_bytes(dword_t data, st_size_t size);
    dword_t res;
    int     nb;
    nb  = 1 << int'(size);
    res = '0;
    for (int b = 0; b < nb; b++) begin
      res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic be_t lane_mask(st_size_t size, logic [2:0] off);
    be_t be;
    int  nb;
    nb = 1 << int'(size);
    be = '0;
    for (int b = 0; b < 8; b++) begin
      if (b >= int'(off) && b < int'(off) + nb) begin
        be[b] = 1'b1;
      end
    end
    return be;
  endfunction

  function automatic dword_t shift_to_lanes(dword_t data, logic [2:0] off);
    dword_t res;
    res = '0;
    for (int b = 0; b + int'(off) < 8; b++) begin
      res[(b + int'(off))*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // call in age order so the younger store overwrites
  function automatic snp_resp_t merge_bytes(snp_resp_t acc, st_wr_t wr, paddr_t addr);
    if (wr.paddr[31:3] == addr[31:3]) begin
      for (int b = 0; b < 8; b++) begin
        if (wr.be[b]) begin
          acc.be[b]          = 1'b1;
          acc.data[b*8 +: 8] = wr.data[b*8 +: 8];
        end
      end
    end
    return acc;
  endfunction

  function automatic st_wr_t expected_write(idx_t idx);
    st_wr_t wr;
    wr.paddr = {st_paddr[idx][31:3], 3'b000};
    wr.be    = lane_mask(st_size[idx], st_paddr[idx][2:0]);
    wr.data  = shift_to_lanes(st_data[idx], st_paddr[idx][2:0]);
    return wr;
  endfunction

  // pulses from the last cycle drop on this falling edge
  task automatic next_cycle();
    @(negedge i_clk);
    i_disp.valid     = 1'b0;
    i_addr_upd.valid = 1'b0;
    i_data_upd.valid = 1'b0;
    i_commit.valid   = 1'b0;
    i_commit.flush   = 1'b0;
    i_snp_valid      = 1'b0;
    if (auto_credit && o_wr_valid) begin
      i_wr_credit = 1'b1;
    end else if (credit_pend > 0) begin
      i_wr_credit = 1'b1;
      credit_pend--;
    end else begin
      i_wr_credit = 1'b0;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic new_store(input paddr_t addr, input st_size_t size, input dword_t data,
                           output idx_t idx);
    int waited;
    waited = 0;
    next_cycle();
    while (!o_disp_ready) begin
      waited++;
      if (waited > 100) begin
        stop_on_error("timeout: the queue never became ready for a dispatch");
      end
      next_cycle();
    end
    check_val("o_disp_idx", o_disp_idx, exp_idx);
    idx            = o_disp_idx;
    i_disp.valid   = 1'b1;
    i_disp.cmt_id  = next_cmt;
    st_cmt[idx]    = next_cmt;
    st_paddr[idx]  = addr;
    st_size[idx]   = size;
    st_data[idx]   = data;
    next_cmt++;
    exp_idx++;
  endtask

  task automatic random_store(output idx_t idx);
    logic [31:0] r;
    paddr_t      addr;
    dword_t      data;
    int          nb;
    r           = $random(seed);
    nb          = 1 << int'(r[1:0]);
    addr        = $random(seed);
    addr[2:0]   = addr[2:0] & 3'(8 - nb);  // naturally aligned
    data[63:32] = $random(seed);
    data[31:0]  = $random(seed);
    new_store(addr, st_size_t'(r[1:0]), keep_low_bytes(data, st_size_t'(r[1:0])), idx);
  endtask

  task automatic drive_addr(input idx_t idx);
    i_addr_upd.valid = 1'b1;
    i_addr_upd.idx   = idx;
    i_addr_upd.paddr = st_paddr[idx];
    i_addr_upd.size  = st_size[idx];
  endtask

  task automatic drive_data(input idx_t idx);
    i_data_upd.valid = 1'b1;
    i_data_upd.idx   = idx;
    i_data_upd.data  = st_data[idx];
  endtask

  // address first, data first, or both together
  task automatic send_ops(input idx_t idx);
    logic [31:0] r;
    r = $random(seed);
    next_cycle();
    if (r[1:0] != 2'd1) begin
      drive_addr(idx);
    end
    if (r[1:0] != 2'd0) begin
      drive_data(idx);
    end
    if (r[1:0] < 2'd2) begin
      next_cycle();
      if (r[1:0] == 2'd0) begin
        drive_data(idx);
      end else begin
        drive_addr(idx);
      end
    end
  endtask

  task automatic commit_store(input idx_t idx);
    next_cycle();
    i_commit.valid  = 1'b1;
    i_commit.cmt_id = st_cmt[idx];
    exp_q.push_back(expected_write(idx));
  endtask

  task automatic do_store();
    idx_t idx;
    random_store(idx);
    send_ops(idx);
    commit_store(idx);
  endtask

  task automatic snoop_store(input paddr_t addr, input st_size_t size);
    idx_t   idx;
    dword_t data;
    data[63:32] = $random(seed);
    data[31:0]  = $random(seed);
    new_store(addr, size, keep_low_bytes(data, size), idx);
    send_ops(idx);
    commit_store(idx);
    snp_exp = merge_bytes(snp_exp, expected_write(idx), snp_addr);
  endtask

  task automatic give_credits(input int n);
    int waited;
    waited      = 0;
    credit_pend = credit_pend + n;
    while (credit_pend != 0) begin
      waited++;
      if (waited > 20) begin
        stop_on_error("timeout: credit pulses were not handed to the DUT");
      end
      next_cycle();
    end
  endtask

  task automatic wait_writes(input int target, input int limit);
    int waited;
    waited = 0;
    while (wr_count < target) begin
      waited++;
      if (waited > limit) begin
        stop_on_error($sformatf("timeout: only %0d of %0d cache writes seen", wr_count, target));
      end
      next_cycle();
    end
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > limit) begin
        stop_on_error("timeout: committed stores never reached the cache");
      end
      next_cycle();
    end
  endtask

  // every write beat against the oldest expected store
  initial begin : scoreboard
    st_wr_t want;
    forever begin
      @(negedge i_clk);
      if (i_reset_n === 1'b1 && o_wr_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          stop_on_error("a cache write appeared with no committed store left to drain");
        end else begin
          want = exp_q.pop_front();
          check_val("o_wr.paddr", o_wr.paddr, want.paddr);
          check_val("o_wr.be", o_wr.be, want.be);
          check_val("o_wr.data", o_wr.data, want.data);
          wr_count++;
        end
      end
    end
  end

  initial begin : stimulus
    idx_t        bidx [4];
    logic [31:0] r;
    int          n;
    int          base;
    seed        = 32'h9cb6;
    next_cmt    = '0;
    exp_idx     = '0;
    wr_count    = 0;
    auto_credit = 1'b1;
    credit_pend = 0;
    snp_exp     = '0;
    i_reset_n   = 1'b0;
    i_disp      = '0;
    i_addr_upd  = '0;
    i_data_upd  = '0;
    i_commit    = '0;
    i_wr_credit = 1'b0;
    i_snp_valid = 1'b0;
    i_snp_paddr = '0;
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    next_cycle();
    check_val("o_wr_valid", o_wr_valid, 1'b0);
    check_val("o_snp.valid", o_snp.valid, 1'b0);
    check_val("o_disp_ready", o_disp_ready, 1'b1);

    // random batches with operands arriving youngest first
    for (int batch = 0; batch < 8; batch++) begin
      r = $random(seed);
      n = 1 + int'(r[1:0]);
      for (int k = 0; k < n; k++) begin
        random_store(bidx[k]);
      end
      for (int k = n - 1; k >= 0; k--) begin
        send_ops(bidx[k]);
      end
      for (int k = 0; k < n; k++) begin
        commit_store(bidx[k]);
      end
    end
    wait_drained(400);
    idle(4);

    // credits withheld
    auto_credit = 1'b0;
    base        = wr_count;
    do_store();
    do_store();
    wait_writes(base + STQ_WR_CREDITS, 100);
    idle(20);
    check_val("write count", wr_count, base + STQ_WR_CREDITS);
    for (int k = 0; k < STQ_ENTRIES; k++) begin
      do_store();
    end
    check_val("o_disp_ready", o_disp_ready, 1'b0);
    check_val("write count", wr_count, base + STQ_WR_CREDITS);
    for (int k = 1; k <= STQ_ENTRIES; k++) begin
      give_credits(1);
      wait_writes(base + STQ_WR_CREDITS + k, 100);
      idle(8);
      check_val("write count", wr_count, base + STQ_WR_CREDITS + k);
    end

    // flush kills the uncommitted tail only
    // older committed stores stay parked until the credits come back
    base = wr_count;
    do_store();
    do_store();
    for (int k = 0; k < 3; k++) begin
      random_store(bidx[k]);
    end
    send_ops(bidx[0]);
    next_cycle();
    drive_addr(bidx[1]);
    next_cycle();
    i_commit.flush = 1'b1;
    idle(20);
    check_val("write count", wr_count, base);
    give_credits(STQ_WR_CREDITS);  // refill the pool
    auto_credit = 1'b1;
    wait_drained(200);
    idle(20);
    check_val("write count", wr_count, base + 2);
    check_val("o_disp_ready", o_disp_ready, 1'b1);
    do_store();
    wait_drained(200);
    idle(4);
    check_val("write count", wr_count, base + 3);

    // snoop over committed stores parked in the queue
    auto_credit = 1'b0;
    base        = wr_count;
    do_store();
    do_store();
    wait_writes(base + STQ_WR_CREDITS, 100);
    r        = $random(seed);
    snp_addr = {r[31:3], 3'b000};
    snp_exp  = '0;
    snoop_store(snp_addr, SZ_D);
    snoop_store(snp_addr + 32'd4, SZ_W);
    snoop_store(snp_addr + 32'd2, SZ_H);
    snoop_store(snp_addr + 32'd5, SZ_B);
    snoop_store(snp_addr + 32'd8, SZ_D);  // next dword stays out
    snoop_store(snp_addr + 32'd6, SZ_H);
    idle(4);
    check_val("write count", wr_count, base + STQ_WR_CREDITS);
    next_cycle();
    i_snp_valid = 1'b1;
    i_snp_paddr = snp_addr | 32'd3;  // byte offset is ignored
    next_cycle();
    check_val("o_snp.valid", o_snp.valid, 1'b1);
    check_val("o_snp.be", o_snp.be, snp_exp.be);
    check_val("o_snp.data", o_snp.data, snp_exp.data);
    i_snp_valid = 1'b1;
    i_snp_paddr = snp_addr + 32'h40;
    next_cycle();
    check_val("o_snp.valid", o_snp.valid, 1'b1);
    check_val("o_snp.be", o_snp.be, 8'h00);
    give_credits(STQ_WR_CREDITS);
    auto_credit = 1'b1;
    wait_drained(400);
    idle(4);

    check_val("pending writes", exp_q.size(), 0);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
